/* adc_capture_pkg.sv */
`include "capture_consts.svh"

package adc_capture_pkg;

  // one ADC's lanes as they arrive each clock
  typedef struct packed {
    logic                        data_valid;
    logic [3:0][`SMP_W-1:0]      datai;
    logic [3:0][`SMP_W-1:0]      dataq;
    logic [1:0]                  outofrange;
    logic [3:0]                  sync;
  } adc_sample_t;

  // lane group feeding a capture buffer
  typedef enum logic [1:0] {
    src_adc0_i = 2'd0,
    src_adc0_q = 2'd1,
    src_adc1_i = 2'd2,
    src_adc1_q = 2'd3
  } lane_src_t;

  // four samples, each with a zero pad bit above it
  typedef logic [4*(`SMP_W+1)-1:0] cap_word_t;

  // one memory write
  typedef struct packed {
    logic [31:0] addr;
    cap_word_t   data;
  } mem_wr_t;

endpackage

/* adc_capture_properties.sv */
`include "capture_consts.svh"

module adc_capture_properties (
  input logic                     clk,
  input logic                     rst,
  input adc_capture_pkg::mem_wr_t mem0_wr,
  input logic                     mem0_valid,
  input logic                     mem0_ready,
  input adc_capture_pkg::mem_wr_t mem1_wr,
  input logic                     mem1_valid,
  input logic                     mem1_ready
);

  // a pending write keeps valid and payload until the memory takes it
  a_mem0_hold: assert property (@(posedge clk) disable iff (rst)
    mem0_valid && !mem0_ready |=> mem0_valid && $stable(mem0_wr))
    else $error("memory 0 write dropped or changed before acceptance");

  a_mem1_hold: assert property (@(posedge clk) disable iff (rst)
    mem1_valid && !mem1_ready |=> mem1_valid && $stable(mem1_wr))
    else $error("memory 1 write dropped or changed before acceptance");

  // writes stay inside the buffer
  a_mem0_addr: assert property (@(posedge clk) disable iff (rst)
    mem0_valid |-> mem0_wr.addr < `CAP_DEPTH)
    else $error("memory 0 write address past the buffer");

  a_mem1_addr: assert property (@(posedge clk) disable iff (rst)
    mem1_valid |-> mem1_wr.addr < `CAP_DEPTH)
    else $error("memory 1 write address past the buffer");

  a_rst_idle: assert property (@(posedge clk) rst |=> !mem0_valid && !mem1_valid)
    else $error("memory valid high after reset");

endmodule

bind adc_capture_top adc_capture_properties u_props (
  .clk        (clk),
  .rst        (rst),
  .mem0_wr    (mem0_wr),
  .mem0_valid (mem0_valid),
  .mem0_ready (mem0_ready),
  .mem1_wr    (mem1_wr),
  .mem1_valid (mem1_valid),
  .mem1_ready (mem1_ready)
);

/* adc_capture_top.sv */
module adc_capture_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [31:0]                 ctrl,
  input  adc_capture_pkg::adc_sample_t adc0,
  input  adc_capture_pkg::adc_sample_t adc1,
  output adc_capture_pkg::mem_wr_t    mem0_wr,
  output logic                        mem0_valid,
  input  logic                        mem0_ready,
  output adc_capture_pkg::mem_wr_t    mem1_wr,
  output logic                        mem1_valid,
  input  logic                        mem1_ready,
  output logic [31:0]                 status,
  output logic [31:0]                 overrange,
  output logic [31:0]                 sync_count0,
  output logic [31:0]                 sync_count1
);
  import adc_capture_pkg::*;

  logic       start;
  logic       busy;
  logic       ovr_clr;
  lane_src_t  src0;
  lane_src_t  src1;
  logic       done0;
  logic       done1;
  logic [1:0] ovr0;
  logic [1:0] ovr1;
  logic [15:0] cnt0;
  logic [15:0] cnt1;

  cap_word_t  word0;
  cap_word_t  word1;
  logic       word0_valid;
  logic       word1_valid;
  logic       word0_ready;
  logic       word1_ready;
  logic       overflow0;
  logic       overflow1;

  capture_ctrl u_ctrl (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .done0   (done0),
    .done1   (done1),
    .start   (start),
    .busy    (busy),
    .src0    (src0),
    .src1    (src1),
    .ovr_clr (ovr_clr)
  );

  adc_monitor u_mon0 (
    .clk        (clk),
    .rst        (rst),
    .adc        (adc0),
    .ovr_clr    (ovr_clr),
    .overrange  (ovr0),
    .sync_count (cnt0)
  );

  adc_monitor u_mon1 (
    .clk        (clk),
    .rst        (rst),
    .adc        (adc1),
    .ovr_clr    (ovr_clr),
    .overrange  (ovr1),
    .sync_count (cnt1)
  );

  lane_select u_sel0 (
    .clk        (clk),
    .rst        (rst),
    .adc0       (adc0),
    .adc1       (adc1),
    .src        (src0),
    .busy       (busy),
    .start      (start),
    .word       (word0),
    .word_valid (word0_valid),
    .word_ready (word0_ready),
    .overflow   (overflow0)
  );

  lane_select u_sel1 (
    .clk        (clk),
    .rst        (rst),
    .adc0       (adc0),
    .adc1       (adc1),
    .src        (src1),
    .busy       (busy),
    .start      (start),
    .word       (word1),
    .word_valid (word1_valid),
    .word_ready (word1_ready),
    .overflow   (overflow1)
  );

  buffer_writer u_wr0 (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .word       (word0),
    .word_valid (word0_valid),
    .word_ready (word0_ready),
    .mem_wr     (mem0_wr),
    .mem_valid  (mem0_valid),
    .mem_ready  (mem0_ready),
    .done       (done0)
  );

  buffer_writer u_wr1 (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .word       (word1),
    .word_valid (word1_valid),
    .word_ready (word1_ready),
    .mem_wr     (mem1_wr),
    .mem_valid  (mem1_valid),
    .mem_ready  (mem1_ready),
    .done       (done1)
  );

  // bit 0 busy, then the two sticky overflow flags
  assign status      = {29'd0, overflow1, overflow0, busy};
  assign overrange   = {22'd0, ovr1, 6'd0, ovr0};
  assign sync_count0 = {16'd0, cnt0};
  assign sync_count1 = {16'd0, cnt1};

endmodule

/* adc_monitor.sv */
module adc_monitor (
  input  logic                        clk,
  input  logic                        rst,
  input  adc_capture_pkg::adc_sample_t adc,
  input  logic                        ovr_clr,
  output logic [1:0]                  overrange,
  output logic [15:0]                 sync_count
);

  logic sync_any;
  logic sync_q;
  logic sync_rise;

  // sticky over-range, one bit per ADC flag
  always_ff @(posedge clk) begin
    if (rst || ovr_clr) begin
      overrange <= 2'b00;
    end else begin
      overrange <= overrange | adc.outofrange;
    end
  end

  // any of the four sync lines
  assign sync_any  = |adc.sync;
  assign sync_rise = sync_any && !sync_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      sync_q <= 1'b0;
    end else begin
      sync_q <= sync_any;
    end
  end

  // wraps at 16 bits
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_count <= 16'd0;
    end else if (sync_rise) begin
      sync_count <= sync_count + 16'd1;
    end
  end

endmodule

/* buffer_writer.sv */
`include "capture_consts.svh"

module buffer_writer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  adc_capture_pkg::cap_word_t word,
  input  logic                       word_valid,
  output logic                       word_ready,
  output adc_capture_pkg::mem_wr_t   mem_wr,
  output logic                       mem_valid,
  input  logic                       mem_ready,
  output logic                       done
);
  import adc_capture_pkg::*;

  // one bit wider than the address so it can reach CAP_DEPTH
  logic [`CAP_AW:0] wr_cnt;
  logic             below;
  logic             take;
  logic             wr_done;
  logic             last_done;

  assign below   = (wr_cnt < `CAP_DEPTH);
  assign wr_done = mem_valid && mem_ready;

  // past the end of the buffer the words are drained and dropped,
  // so the holding stage never backs up into an overflow
  assign word_ready = below ? (!mem_valid || mem_ready) : 1'b1;
  assign take       = word_valid && word_ready && below && !start;

  assign last_done = wr_done && (mem_wr.addr == `CAP_DEPTH - 1);

  always_ff @(posedge clk) begin
    if (rst || start) begin
      wr_cnt <= '0;
    end else if (take) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || start) begin
      mem_valid <= 1'b0;
    end else if (take) begin
      mem_valid <= 1'b1;
    end else if (wr_done) begin
      mem_valid <= 1'b0;
    end
  end

  // write payload, loaded at the current address
  always_ff @(posedge clk) begin
    if (take) begin
      mem_wr.addr <= 32'(wr_cnt);
      mem_wr.data <= word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || start) begin
      done <= 1'b0;
    end else if (last_done) begin
      done <= 1'b1;
    end
  end

endmodule

/* capture_consts.svh */
`ifndef CAPTURE_CONSTS_SVH
`define CAPTURE_CONSTS_SVH

// words per capture buffer, kept small for simulation
`define CAP_DEPTH 16

// memory address width needed to cover CAP_DEPTH words
`define CAP_AW 4

// ADC sample width
`define SMP_W 8

// bit positions in the 32-bit control word
`define CTRL_START   0
`define CTRL_OVR_CLR 4
`define CTRL_SRC0_LO 8
`define CTRL_SRC1_LO 12

`endif

/* capture_ctrl.sv */
`include "capture_consts.svh"

module capture_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [31:0]               ctrl,
  input  logic                      done0,
  input  logic                      done1,
  output logic                      start,
  output logic                      busy,
  output adc_capture_pkg::lane_src_t src0,
  output adc_capture_pkg::lane_src_t src1,
  output logic                      ovr_clr
);
  import adc_capture_pkg::*;

  typedef enum logic {
    st_wait,
    st_write
  } state_t;

  state_t state;
  logic   start_bit_q;
  logic   start_edge;

  // rising edge of the start bit
  assign start_edge = ctrl[`CTRL_START] && !start_bit_q;

  // registered start pulse, edges seen during a capture are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      start_bit_q <= 1'b0;
      start       <= 1'b0;
    end else begin
      start_bit_q <= ctrl[`CTRL_START];
      start       <= start_edge && !busy;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_wait;
    end else begin
      case (state)
        st_wait: begin
          if (start) begin
            state <= st_write;
          end
        end
        st_write: begin
          // both buffers have written their last word
          if (done0 && done1) begin
            state <= st_wait;
          end
        end
        default: begin
          state <= st_wait;
        end
      endcase
    end
  end

  assign busy = (state == st_write);

  // source selects and over-range clear follow the control word
  always_ff @(posedge clk) begin
    if (rst) begin
      src0    <= src_adc0_i;
      src1    <= src_adc0_i;
      ovr_clr <= 1'b0;
    end else begin
      src0    <= lane_src_t'(ctrl[`CTRL_SRC0_LO +: 2]);
      src1    <= lane_src_t'(ctrl[`CTRL_SRC1_LO +: 2]);
      ovr_clr <= ctrl[`CTRL_OVR_CLR];
    end
  end

endmodule

/* capture_trace.txt */
# cycles(dec) ctrl v0 i0 q0 or0 sync0 v1 i1 q1 or1 sync1 ready0 ready1 rnd, hex except cycles
# rnd bit 0 random samples, bit 1 random memory ready, bit 2 random data valid
4 00003000 0 00000000 00000000 0 0 0 00000000 00000000 0 0 1 1 0
1 00003000 0 00000000 00000000 1 1 0 00000000 00000000 0 2 1 1 0
2 00003000 0 00000000 00000000 2 0 0 00000000 00000000 1 0 1 1 0
1 00003001 1 11223344 55667788 0 0 1 99aabbcc ddeeff01 0 0 1 1 0
30 00003001 1 00000000 00000000 0 8 1 00000000 00000000 0 0 1 1 1
3 00003000 0 00000000 00000000 0 0 0 00000000 00000000 2 3 1 1 0
1 00002101 0 00000000 00000000 0 0 0 00000000 00000000 0 0 1 1 7
3 00002100 0 00000000 00000000 0 1 0 00000000 00000000 0 0 1 1 7
1 00002101 0 00000000 00000000 0 0 0 00000000 00000000 0 0 1 1 7
80 00002100 0 00000000 00000000 0 0 0 00000000 00000000 0 0 1 1 7
2 00002110 0 00000000 00000000 0 4 0 00000000 00000000 0 0 1 1 0
2 00002100 0 00000000 00000000 2 0 0 00000000 00000000 0 1 1 1 0
3 00000300 0 00000000 00000000 0 0 0 00000000 00000000 0 0 1 1 0
1 00000301 1 a1a2a3a4 b1b2b3b4 0 0 1 c1c2c3c4 d1d2d3d4 0 0 0 0 0
10 00000300 1 00000000 00000000 0 0 1 00000000 00000000 0 0 0 0 1
30 00000300 1 00000000 00000000 0 0 1 00000000 00000000 0 0 1 1 1
3 00000300 0 00000000 00000000 0 0 0 00000000 00000000 0 0 1 1 0
1 00001201 1 0f1e2d3c 4b5a6978 0 0 1 8796a5b4 c3d2e1f0 0 0 1 1 0
30 00001200 1 00000000 00000000 0 0 1 00000000 00000000 0 0 1 1 1
3 00001200 0 00000000 00000000 0 0 0 00000000 00000000 0 0 1 1 0
1 00003101 1 00000000 00000000 0 0 1 00000000 00000000 0 0 1 1 3
60 00003100 1 00000000 00000000 0 0 1 00000000 00000000 0 0 0 0 3
4 00003100 0 00000000 00000000 0 0 0 00000000 00000000 0 0 1 1 0

/* lane_select.sv */
`include "capture_consts.svh"

module lane_select (
  input  logic                        clk,
  input  logic                        rst,
  input  adc_capture_pkg::adc_sample_t adc0,
  input  adc_capture_pkg::adc_sample_t adc1,
  input  adc_capture_pkg::lane_src_t  src,
  input  logic                        busy,
  input  logic                        start,
  output adc_capture_pkg::cap_word_t  word,
  output logic                        word_valid,
  input  logic                        word_ready,
  output logic                        overflow
);
  import adc_capture_pkg::*;

  logic                   sel_valid;
  logic [3:0][`SMP_W-1:0] sel_smp;
  cap_word_t              packed_word;
  logic                   full;
  logic                   drain;
  logic                   load;

  always_comb begin
    case (src)
      src_adc0_i: begin
        sel_valid = adc0.data_valid;
        sel_smp   = adc0.datai;
      end
      src_adc0_q: begin
        sel_valid = adc0.data_valid;
        sel_smp   = adc0.dataq;
      end
      src_adc1_i: begin
        sel_valid = adc1.data_valid;
        sel_smp   = adc1.datai;
      end
      default: begin
        sel_valid = adc1.data_valid;
        sel_smp   = adc1.dataq;
      end
    endcase
    // sample 0 lands in the top bits
    for (int i = 0; i < 4; i++) begin
      packed_word[(3-i)*(`SMP_W+1) +: `SMP_W+1] = {1'b0, sel_smp[i]};
    end
  end

  assign drain = full && word_ready;
  assign load  = busy && sel_valid && (!full || drain);

  always_ff @(posedge clk) begin
    if (rst || start) begin
      full     <= 1'b0;
      overflow <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else begin
      if (drain) begin
        full <= 1'b0;
      end
      // sample arrived with nowhere to go
      if (busy && sel_valid) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      word <= packed_word;
    end
  end

  assign word_valid = full;

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, the log decides the result
{ verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_capture \
    -f sim.f -o sim_capture && ./obj_dir/sim_capture; } > sim.log 2>&1 ||
  echo "build or simulation exited with an error" >> sim.log
grep -q "ERRORS FOUND" sim.log && echo "simulation failed, see sim.log" && exit 1
grep -q "^NO ERRORS" sim.log || { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"

/* sim.f */
+incdir+.
adc_capture_pkg.sv
capture_ctrl.sv
adc_monitor.sv
lane_select.sv
buffer_writer.sv
adc_capture_top.sv
adc_capture_properties.sv
tb_adc_capture.sv

/* tb_adc_capture.sv */
`include "capture_consts.svh"

module tb_adc_capture;
  import adc_capture_pkg::*;

  logic        clk;
  logic        rst;
  logic [31:0] ctrl;
  adc_sample_t adc0;
  adc_sample_t adc1;
  mem_wr_t     mem0_wr;
  mem_wr_t     mem1_wr;
  logic        mem0_valid;
  logic        mem1_valid;
  logic        mem0_ready;
  logic        mem1_ready;
  logic [31:0] status;
  logic [31:0] overrange;
  logic [31:0] sync_count0;
  logic [31:0] sync_count1;

  // fields of the trace line being played
  int          t_cyc;
  logic [31:0] t_ctrl, t_v0, t_i0, t_q0, t_o0, t_s0;
  logic [31:0] t_v1, t_i1, t_q1, t_o1, t_s1, t_r0, t_r1, t_rnd;
  string       trace[$];
  logic        rst_next;
  logic [31:0] lfsr;
  int          limit;
  int          cycles;

  // reference model state
  logic        st_q, st_p, busy_m, oclr_m;
  logic [1:0]  src_m [2];
  logic        full_m [2], ovf_m [2], mval_m [2], done_m [2], syq_m [2];
  logic [35:0] hold_m [2], mdat_m [2];
  int          cnt_m [2], madr_m [2];
  logic [1:0]  ovr_m [2];
  logic [15:0] scnt_m [2];

  adc_capture_top UUT (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run went past %0d cycles", limit);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // sample 0 goes to the top with a zero pad bit above every sample
  function automatic logic [35:0] pack_lanes(input logic [31:0] l);
    return {1'b0, l[7:0], 1'b0, l[15:8], 1'b0, l[23:16], 1'b0, l[31:24]};
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic load_line(input string line);
    if ($sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h", t_cyc, t_ctrl,
                t_v0, t_i0, t_q0, t_o0, t_s0, t_v1, t_i1, t_q1, t_o1, t_s1,
                t_r0, t_r1, t_rnd) != 15) begin
      $display("trace line could not be read: %s", line);
      $display("ERRORS FOUND");
      $fatal(1, "bad trace line");
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] i0, q0, i1, q1, rb;
    logic        v0, v1;
    i0 = t_i0;
    q0 = t_q0;
    i1 = t_i1;
    q1 = t_q1;
    v0 = t_v0[0];
    v1 = t_v1[0];
    if (t_rnd[0]) begin
      i0 = rand_bits(32);
      q0 = rand_bits(32);
      i1 = rand_bits(32);
      q1 = rand_bits(32);
    end
    if (t_rnd[2]) begin
      rb = rand_bits(2);
      v0 = rb[0];
      v1 = rb[1];
    end
    rst  = rst_next;
    ctrl = t_ctrl;
    adc0 = {v0, i0, q0, t_o0[1:0], t_s0[3:0]};
    adc1 = {v1, i1, q1, t_o1[1:0], t_s1[3:0]};
    if (t_rnd[1]) begin
      rb = rand_bits(2);
      mem0_ready = rb[0];
      mem1_ready = rb[1];
    end else begin
      mem0_ready = t_r0[0];
      mem1_ready = t_r1[0];
    end
  endtask

  // advance the model over one clock edge using the inputs seen at that edge
  task automatic model_step();
    adc_sample_t a [2];
    logic        rdy [2];
    logic [31:0] lanes;
    logic        sv, below, wrdy, take, drain, load, xfer, last;
    logic        edge_p, busy_nx;
    a[0]   = adc0;
    a[1]   = adc1;
    rdy[0] = mem0_ready;
    rdy[1] = mem1_ready;
    if (rst) begin
      st_q   = 1'b0;
      st_p   = 1'b0;
      busy_m = 1'b0;
      oclr_m = 1'b0;
      for (int b = 0; b < 2; b++) begin
        src_m[b]  = 2'd0;
        full_m[b] = 1'b0;
        ovf_m[b]  = 1'b0;
        mval_m[b] = 1'b0;
        done_m[b] = 1'b0;
        cnt_m[b]  = 0;
        ovr_m[b]  = 2'd0;
        syq_m[b]  = 1'b0;
        scnt_m[b] = 16'd0;
      end
      return;
    end
    edge_p  = ctrl[`CTRL_START] && !st_q;
    busy_nx = busy_m ? !(done_m[0] && done_m[1]) : st_p;
    for (int b = 0; b < 2; b++) begin
      ovr_m[b] = oclr_m ? 2'd0 : (ovr_m[b] | a[b].outofrange);
      if ((|a[b].sync) && !syq_m[b]) begin
        scnt_m[b] = scnt_m[b] + 16'd1;
      end
      syq_m[b] = |a[b].sync;
      // src bit 1 picks the ADC and bit 0 picks Q over I
      sv    = a[src_m[b][1]].data_valid;
      lanes = src_m[b][0] ? a[src_m[b][1]].dataq : a[src_m[b][1]].datai;
      // past the end of the buffer words are drained and dropped
      below = cnt_m[b] < `CAP_DEPTH;
      wrdy  = below ? (!mval_m[b] || rdy[b]) : 1'b1;
      xfer  = mval_m[b] && rdy[b];
      take  = full_m[b] && wrdy && below && !st_p;
      drain = full_m[b] && wrdy;
      load  = busy_m && sv && (!full_m[b] || drain);
      last  = xfer && (madr_m[b] == `CAP_DEPTH - 1);
      if (st_p) begin
        cnt_m[b]  = 0;
        mval_m[b] = 1'b0;
        done_m[b] = 1'b0;
        full_m[b] = 1'b0;
        ovf_m[b]  = 1'b0;
      end else begin
        if (take) begin
          madr_m[b] = cnt_m[b];
          mdat_m[b] = hold_m[b];
          mval_m[b] = 1'b1;
          cnt_m[b]  = cnt_m[b] + 1;
        end else if (xfer) begin
          mval_m[b] = 1'b0;
        end
        if (last) begin
          done_m[b] = 1'b1;
        end
        if (load) begin
          full_m[b] = 1'b1;
        end else if (drain) begin
          full_m[b] = 1'b0;
        end
        if (!load && busy_m && sv) begin
          ovf_m[b] = 1'b1;
        end
      end
      if (load) begin
        hold_m[b] = pack_lanes(lanes);
      end
    end
    st_q     = ctrl[`CTRL_START];
    st_p     = edge_p && !busy_m;
    busy_m   = busy_nx;
    src_m[0] = ctrl[`CTRL_SRC0_LO +: 2];
    src_m[1] = ctrl[`CTRL_SRC1_LO +: 2];
    oclr_m   = ctrl[`CTRL_OVR_CLR];
  endtask

  task automatic compare_outputs();
    mem_wr_t w [2];
    logic    v [2];
    w[0] = mem0_wr;
    w[1] = mem1_wr;
    v[0] = mem0_valid;
    v[1] = mem1_valid;
    for (int b = 0; b < 2; b++) begin
      check($sformatf("mem%0d_valid", b), v[b], mval_m[b]);
      if (mval_m[b]) begin
        check($sformatf("mem%0d_wr.addr", b), w[b].addr, madr_m[b]);
        check($sformatf("mem%0d_wr.data", b), w[b].data, mdat_m[b]);
      end
    end
    check("status", status, {29'd0, ovf_m[1], ovf_m[0], busy_m});
    check("overrange", overrange, {22'd0, ovr_m[1], 6'd0, ovr_m[0]});
    check("sync_count0", sync_count0, {16'd0, scnt_m[0]});
    check("sync_count1", sync_count1, {16'd0, scnt_m[1]});
  endtask

  task automatic run_cycle();
    @(posedge clk);
    model_step();
    #2;
    drive_inputs();
    @(negedge clk);
    compare_outputs();
  endtask

  initial begin
    int    fd;
    int    n;
    int    total;
    string line;
    clk      = 1'b0;
    lfsr     = 32'hf394;
    rst_next = 1'b1;
    limit    = 0;
    cycles   = 0;
    // idle inputs with memory ready while in reset
    load_line("0 0 0 0 0 0 0 0 0 0 0 0 1 1 0");
    drive_inputs();
    fd = $fopen("capture_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open capture_trace.txt");
      $display("ERRORS FOUND");
      $fatal(1, "trace file missing");
    end
    total = 0;
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
        trace.push_back(line);
        if ($sscanf(line, "%d", n) == 1) begin
          total += n;
        end
      end
    end
    $fclose(fd);
    limit = total + 4 + 4 * `CAP_DEPTH;
    repeat (3) run_cycle();
    rst_next = 1'b0;
    run_cycle();
    foreach (trace[k]) begin
      load_line(trace[k]);
      repeat (t_cyc) run_cycle();
    end
    // a capture still running finishes on a steady stream
    t_ctrl = t_ctrl & ~32'd1;
    t_v0   = 32'd1;
    t_v1   = 32'd1;
    t_rnd  = 32'd1;
    t_r0   = 32'd1;
    t_r1   = 32'd1;
    while (status[0] || busy_m) begin
      run_cycle();
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule
